//--- source/task_unit_pkg.sv
package task_unit_pkg;

   // One queued task as it moves between the ports and the FIFOs
   typedef struct packed {
      logic [3:0]  ttype;
      logic [31:0] locale;
      logic [31:0] ts;
      logic        producer;
      logic [31:0] args;
   } task_t;

   localparam int TASK_WIDTH = $bits(task_t);

   // Producer tasks of this type go to the splitter
   localparam logic [3:0] TASK_TYPE_SPLITTER = 4'hf;

   // Default queue depth is 64 entries
   localparam int LOG_TQ_SIZE = 6;
   localparam int SPILL_CNT_WIDTH = 8;

   // Occupancy needs one bit more than the pointers
   typedef logic [LOG_TQ_SIZE:0] tq_count_t;
   typedef logic [SPILL_CNT_WIDTH-1:0] spill_cnt_t;

endpackage

//--- source/task_unit_cfg_pkg.sv
package task_unit_cfg_pkg;

   typedef struct packed {
      logic        valid;
      logic [7:0]  addr;
      logic [15:0] data;
   } cfg_write_t;

   localparam logic [7:0] CFG_SPILL_THRESHOLD             = 8'h10;
   localparam logic [7:0] CFG_SPILL_SIZE                  = 8'h14;
   localparam logic [7:0] CFG_PRODUCER_PRIORITY_THRESHOLD = 8'h18;

   localparam task_unit_pkg::tq_count_t  DEFAULT_SPILL_THRESHOLD             = 48;
   localparam task_unit_pkg::spill_cnt_t DEFAULT_SPILL_SIZE                  = 16;
   localparam task_unit_pkg::tq_count_t  DEFAULT_PRODUCER_PRIORITY_THRESHOLD = 40;

   // Thresholds currently in force
   typedef struct packed {
      task_unit_pkg::tq_count_t  spill_threshold;
      task_unit_pkg::spill_cnt_t spill_size;
      task_unit_pkg::tq_count_t  producer_priority_threshold;
   } task_unit_cfg_t;

endpackage

//--- source/task_fifo.sv
`timescale 1ns/1ps

module task_fifo #(
   parameter int LOG_DEPTH = 6
) (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  wr_en,
   input  task_unit_pkg::task_t  wr_data,
   input  logic                  rd_en,
   output task_unit_pkg::task_t  rd_data,
   output logic                  full,
   output logic                  empty,
   output logic [LOG_DEPTH:0]    count
);

   localparam int DEPTH = 1 << LOG_DEPTH;

   logic [task_unit_pkg::TASK_WIDTH-1:0] mem [DEPTH];
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH-1:0] rd_ptr;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + (LOG_DEPTH+1)'(wr_en) - (LOG_DEPTH+1)'(rd_en);
      end
   end

   // Head is visible without a read cycle
   assign rd_data = mem[rd_ptr];
   assign full    = (count == (LOG_DEPTH+1)'(DEPTH));
   assign empty   = (count == '0);

   assert property (@(posedge clk) disable iff (!rstn) !(wr_en && full));
   assert property (@(posedge clk) disable iff (!rstn) !(rd_en && empty));

endmodule

//--- source/admit_spill_ctrl.sv
`timescale 1ns/1ps

module admit_spill_ctrl #(
   parameter int LOG_DEPTH = 6
) (
   input  logic                            clk,
   input  logic                            rstn,
   input  task_unit_cfg_pkg::task_unit_cfg_t cfg,
   input  logic                            task_enq_valid,
   input  task_unit_pkg::task_t            task_enq_data,
   input  logic                            coal_child_valid,
   input  task_unit_pkg::task_t            coal_child_data,
   input  logic                            normal_full,
   input  logic [LOG_DEPTH:0]              normal_count,
   input  logic [LOG_DEPTH:0]              producer_count,
   input  logic                            overflow_ready,
   output logic                            task_enq_ready,
   output logic                            coal_child_ready,
   output logic                            normal_wr_en,
   output logic                            producer_wr_en,
   output task_unit_pkg::task_t            wr_data,
   output logic                            almost_full,
   output logic                            spilling,
   output logic                            spill_producer,
   output logic                            overflow_valid
);

   task_unit_pkg::tq_count_t  normal_cnt;
   task_unit_pkg::tq_count_t  producer_cnt;
   task_unit_pkg::spill_cnt_t spills_remaining;
   logic                      accept;

   assign normal_cnt   = task_unit_pkg::tq_count_t'(normal_count);
   assign producer_cnt = task_unit_pkg::tq_count_t'(producer_count);

   // Coalescer children take priority over new tasks
   assign coal_child_ready = coal_child_valid & !normal_full;
   assign task_enq_ready   = task_enq_valid & !coal_child_ready & !almost_full;
   assign wr_data          = coal_child_ready ? coal_child_data : task_enq_data;
   assign accept           = coal_child_ready | task_enq_ready;
   assign normal_wr_en     = accept & !wr_data.producer;
   assign producer_wr_en   = accept & wr_data.producer;

   assign almost_full = (normal_cnt > cfg.spill_threshold) |
                        (producer_cnt > cfg.spill_threshold);

   assign spilling       = (spills_remaining != '0);
   assign overflow_valid = spilling;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         spills_remaining <= '0;
         spill_producer   <= 1'b0;
      end else if (!spilling && almost_full) begin
         spills_remaining <= cfg.spill_size;
         spill_producer   <= (producer_cnt > cfg.spill_threshold);
      end else if (overflow_valid && overflow_ready) begin
         spills_remaining <= spills_remaining - 1'b1;
      end
   end

   assert property (@(posedge clk) disable iff (!rstn)
      coal_child_valid && coal_child_ready |-> !coal_child_data.producer);

   // Source FIFO must not run dry mid-burst
   assert property (@(posedge clk) disable iff (!rstn)
      spilling |-> (spill_producer ? producer_count != '0 : normal_count != '0));

endmodule

//--- source/deq_arbiter.sv
`timescale 1ns/1ps

module deq_arbiter #(
   parameter int LOG_DEPTH = 6
) (
   input  task_unit_cfg_pkg::task_unit_cfg_t cfg,
   input  logic                            spilling,
   input  logic                            spill_producer,
   input  logic                            overflow_ready,
   input  task_unit_pkg::task_t            normal_head,
   input  logic                            normal_empty,
   input  logic [LOG_DEPTH:0]              normal_count,
   input  task_unit_pkg::task_t            producer_head,
   input  logic                            producer_empty,
   input  logic                            task_deq_ready,
   input  logic                            splitter_deq_ready,
   output logic                            task_deq_valid,
   output task_unit_pkg::task_t            task_deq_data,
   output logic                            splitter_deq_valid,
   output task_unit_pkg::task_t            splitter_deq_task,
   output task_unit_pkg::task_t            overflow_data,
   output logic                            normal_rd_en,
   output logic                            producer_rd_en
);

   logic deq_producer;
   logic producer_is_splitter;

   // Producers win while the normal queue runs low
   assign deq_producer = (task_unit_pkg::tq_count_t'(normal_count) <
                          cfg.producer_priority_threshold) & !producer_empty;
   assign producer_is_splitter = (producer_head.ttype == task_unit_pkg::TASK_TYPE_SPLITTER);

   assign task_deq_data     = deq_producer ? producer_head : normal_head;
   assign splitter_deq_task = producer_head;
   assign overflow_data     = spill_producer ? producer_head : normal_head;

   always_comb begin
      task_deq_valid     = 1'b0;
      splitter_deq_valid = 1'b0;
      normal_rd_en       = 1'b0;
      producer_rd_en     = 1'b0;
      if (!spilling) begin
         if (deq_producer) begin
            if (producer_is_splitter) begin
               splitter_deq_valid = 1'b1;
               producer_rd_en     = splitter_deq_ready;
            end else begin
               task_deq_valid = 1'b1;
               producer_rd_en = task_deq_ready;
            end
         end else if (!normal_empty) begin
            task_deq_valid = 1'b1;
            normal_rd_en   = task_deq_ready;
         end
      end else if (overflow_ready) begin
         // One read per overflow transfer
         producer_rd_en = spill_producer;
         normal_rd_en   = !spill_producer;
      end
   end

endmodule

//--- source/task_unit_regs.sv
`timescale 1ns/1ps

module task_unit_regs #(
   parameter int LOG_DEPTH = 6
) (
   input  logic                              clk,
   input  logic                              rstn,
   input  task_unit_cfg_pkg::cfg_write_t     cfg_wr,
   output task_unit_cfg_pkg::task_unit_cfg_t cfg
);

   localparam int MAX_COUNT = (1 << LOG_DEPTH) - 1;

   // Above this a threshold could never be reached before the FIFO fills
   function automatic task_unit_pkg::tq_count_t clamp_count(input logic [15:0] value);
      if (value > 16'(MAX_COUNT)) begin
         return task_unit_pkg::tq_count_t'(MAX_COUNT);
      end else begin
         return task_unit_pkg::tq_count_t'(value);
      end
   endfunction

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cfg.spill_threshold             <= task_unit_cfg_pkg::DEFAULT_SPILL_THRESHOLD;
         cfg.spill_size                  <= task_unit_cfg_pkg::DEFAULT_SPILL_SIZE;
         cfg.producer_priority_threshold <= task_unit_cfg_pkg::DEFAULT_PRODUCER_PRIORITY_THRESHOLD;
      end else if (cfg_wr.valid) begin
         case (cfg_wr.addr)
            task_unit_cfg_pkg::CFG_SPILL_THRESHOLD:
               cfg.spill_threshold <= clamp_count(cfg_wr.data);
            task_unit_cfg_pkg::CFG_SPILL_SIZE:
               cfg.spill_size <= cfg_wr.data[task_unit_pkg::SPILL_CNT_WIDTH-1:0];
            task_unit_cfg_pkg::CFG_PRODUCER_PRIORITY_THRESHOLD:
               cfg.producer_priority_threshold <= clamp_count(cfg_wr.data);
            default: begin
            end
         endcase
      end
   end

endmodule

//--- source/task_unit_unordered.sv
`timescale 1ns/1ps

module task_unit_unordered #(
   parameter int LOG_DEPTH = task_unit_pkg::LOG_TQ_SIZE
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          task_enq_valid,
   output logic                          task_enq_ready,
   input  task_unit_pkg::task_t          task_enq_data,
   input  logic                          coal_child_valid,
   output logic                          coal_child_ready,
   input  task_unit_pkg::task_t          coal_child_data,
   input  logic                          overflow_ready,
   output logic                          overflow_valid,
   output task_unit_pkg::task_t          overflow_data,
   input  logic                          task_deq_ready,
   output logic                          task_deq_valid,
   output task_unit_pkg::task_t          task_deq_data,
   input  logic                          splitter_deq_ready,
   output logic                          splitter_deq_valid,
   output task_unit_pkg::task_t          splitter_deq_task,
   input  task_unit_cfg_pkg::cfg_write_t cfg_wr,
   output logic                          full,
   output logic                          almost_full,
   output logic                          empty
);

   task_unit_cfg_pkg::task_unit_cfg_t cfg;
   task_unit_pkg::task_t              wr_data;
   task_unit_pkg::task_t              normal_head;
   task_unit_pkg::task_t              producer_head;
   logic                              normal_wr_en;
   logic                              producer_wr_en;
   logic                              normal_rd_en;
   logic                              producer_rd_en;
   logic                              producer_empty;
   logic [LOG_DEPTH:0]                normal_count;
   logic [LOG_DEPTH:0]                producer_count;
   logic                              spilling;
   logic                              spill_producer;

   task_fifo #(.LOG_DEPTH(LOG_DEPTH)) normal_fifo (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (normal_wr_en),
      .wr_data (wr_data),
      .rd_en   (normal_rd_en),
      .rd_data (normal_head),
      .full    (full),
      .empty   (empty),
      .count   (normal_count)
   );

   // Producer FIFO cannot overflow while almost_full gates enqueue
   task_fifo #(.LOG_DEPTH(LOG_DEPTH)) producer_fifo (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (producer_wr_en),
      .wr_data (wr_data),
      .rd_en   (producer_rd_en),
      .rd_data (producer_head),
      .full    (),
      .empty   (producer_empty),
      .count   (producer_count)
   );

   admit_spill_ctrl #(.LOG_DEPTH(LOG_DEPTH)) admit_spill_ctrl_i (
      .clk              (clk),
      .rstn             (rstn),
      .cfg              (cfg),
      .task_enq_valid   (task_enq_valid),
      .task_enq_data    (task_enq_data),
      .coal_child_valid (coal_child_valid),
      .coal_child_data  (coal_child_data),
      .normal_full      (full),
      .normal_count     (normal_count),
      .producer_count   (producer_count),
      .overflow_ready   (overflow_ready),
      .task_enq_ready   (task_enq_ready),
      .coal_child_ready (coal_child_ready),
      .normal_wr_en     (normal_wr_en),
      .producer_wr_en   (producer_wr_en),
      .wr_data          (wr_data),
      .almost_full      (almost_full),
      .spilling         (spilling),
      .spill_producer   (spill_producer),
      .overflow_valid   (overflow_valid)
   );

   deq_arbiter #(.LOG_DEPTH(LOG_DEPTH)) deq_arbiter_i (
      .cfg                (cfg),
      .spilling           (spilling),
      .spill_producer     (spill_producer),
      .overflow_ready     (overflow_ready),
      .normal_head        (normal_head),
      .normal_empty       (empty),
      .normal_count       (normal_count),
      .producer_head      (producer_head),
      .producer_empty     (producer_empty),
      .task_deq_ready     (task_deq_ready),
      .splitter_deq_ready (splitter_deq_ready),
      .task_deq_valid     (task_deq_valid),
      .task_deq_data      (task_deq_data),
      .splitter_deq_valid (splitter_deq_valid),
      .splitter_deq_task  (splitter_deq_task),
      .overflow_data      (overflow_data),
      .normal_rd_en       (normal_rd_en),
      .producer_rd_en     (producer_rd_en)
   );

   task_unit_regs #(.LOG_DEPTH(LOG_DEPTH)) task_unit_regs_i (
      .clk    (clk),
      .rstn   (rstn),
      .cfg_wr (cfg_wr),
      .cfg    (cfg)
   );

endmodule

//--- sim/task_unit_checker.sv
`timescale 1ns/1ps

module task_unit_checker #(
   parameter int LOG_DEPTH = 6
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          task_enq_valid,
   input  logic                          task_enq_ready,
   input  task_unit_pkg::task_t          task_enq_data,
   input  logic                          coal_child_valid,
   input  logic                          coal_child_ready,
   input  task_unit_pkg::task_t          coal_child_data,
   input  logic                          overflow_valid,
   input  logic                          overflow_ready,
   input  task_unit_pkg::task_t          overflow_data,
   input  logic                          task_deq_valid,
   input  logic                          task_deq_ready,
   input  task_unit_pkg::task_t          task_deq_data,
   input  logic                          splitter_deq_valid,
   input  logic                          splitter_deq_ready,
   input  task_unit_pkg::task_t          splitter_deq_task,
   input  task_unit_cfg_pkg::cfg_write_t cfg_wr,
   input  logic                          full,
   input  logic                          almost_full,
   input  logic                          empty,
   output int                            error_count,
   output int                            check_count,
   output int                            spill_transfers
);

   localparam int DEPTH = 1 << LOG_DEPTH;

   task_unit_pkg::task_t normal_q[$];
   task_unit_pkg::task_t producer_q[$];
   int   spill_thr;
   int   spill_size;
   int   prio_thr;
   int   spill_left;
   logic spill_prod;
   int   n_cnt;
   int   p_cnt;
   logic exp_spilling;
   logic exp_almost_full;
   logic exp_coal_ready;
   logic exp_enq_ready;
   logic exp_deq_valid;
   logic exp_split_valid;
   logic pick_producer;
   logic src_ok;

   task automatic compare_bit(input string name, input logic exp, input logic act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("ERROR t=%0t %s expected %b got %b", $time, name, exp, act);
      end
   endtask

   task automatic compare_task(input string name, input task_unit_pkg::task_t exp,
                               input task_unit_pkg::task_t act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   always @(posedge clk) begin
      if (!rstn) begin
         normal_q.delete();
         producer_q.delete();
         spill_thr       = int'(task_unit_cfg_pkg::DEFAULT_SPILL_THRESHOLD);
         spill_size      = int'(task_unit_cfg_pkg::DEFAULT_SPILL_SIZE);
         prio_thr        = int'(task_unit_cfg_pkg::DEFAULT_PRODUCER_PRIORITY_THRESHOLD);
         spill_left      = 0;
         spill_prod      = 1'b0;
         error_count     = 0;
         check_count     = 0;
         spill_transfers = 0;
      end else begin
         // Expected responses from the state before this edge
         n_cnt           = normal_q.size();
         p_cnt           = producer_q.size();
         exp_spilling    = (spill_left != 0);
         exp_almost_full = (n_cnt > spill_thr) || (p_cnt > spill_thr);
         exp_coal_ready  = coal_child_valid && (n_cnt != DEPTH);
         exp_enq_ready   = task_enq_valid && !exp_coal_ready && !exp_almost_full;
         exp_deq_valid   = 1'b0;
         exp_split_valid = 1'b0;
         pick_producer   = 1'b0;
         if (!exp_spilling) begin
            if (n_cnt < prio_thr && p_cnt > 0) begin
               pick_producer = 1'b1;
               if (producer_q[0].ttype == task_unit_pkg::TASK_TYPE_SPLITTER) begin
                  exp_split_valid = 1'b1;
               end else begin
                  exp_deq_valid = 1'b1;
               end
            end else if (n_cnt > 0) begin
               exp_deq_valid = 1'b1;
            end
         end

         compare_bit("coal_child_ready", exp_coal_ready, coal_child_ready);
         compare_bit("task_enq_ready", exp_enq_ready, task_enq_ready);
         compare_bit("almost_full", exp_almost_full, almost_full);
         compare_bit("full", n_cnt == DEPTH, full);
         compare_bit("empty", n_cnt == 0, empty);
         compare_bit("overflow_valid", exp_spilling, overflow_valid);
         compare_bit("task_deq_valid", exp_deq_valid, task_deq_valid);
         compare_bit("splitter_deq_valid", exp_split_valid, splitter_deq_valid);
         if (exp_deq_valid) begin
            compare_task("task_deq_data", pick_producer ? producer_q[0] : normal_q[0],
                         task_deq_data);
         end
         if (exp_split_valid) begin
            compare_task("splitter_deq_task", producer_q[0], splitter_deq_task);
         end
         src_ok = spill_prod ? (p_cnt > 0) : (n_cnt > 0);
         if (exp_spilling && !src_ok) begin
            error_count++;
            $display("Spill is running but its source queue in the model is empty");
         end else if (exp_spilling) begin
            compare_task("overflow_data", spill_prod ? producer_q[0] : normal_q[0],
                         overflow_data);
         end

         // Pops before pushes, heads come from the old state
         if ((exp_deq_valid && task_deq_ready) || (exp_split_valid && splitter_deq_ready)) begin
            if (pick_producer) begin
               void'(producer_q.pop_front());
            end else begin
               void'(normal_q.pop_front());
            end
         end
         if (exp_spilling && overflow_ready && src_ok) begin
            spill_transfers++;
            if (spill_prod) begin
               void'(producer_q.pop_front());
            end else begin
               void'(normal_q.pop_front());
            end
         end
         if (exp_coal_ready) begin
            normal_q.push_back(coal_child_data);
         end else if (exp_enq_ready && task_enq_data.producer) begin
            producer_q.push_back(task_enq_data);
         end else if (exp_enq_ready) begin
            normal_q.push_back(task_enq_data);
         end

         // Burst starts on almost_full with no spill running
         if (!exp_spilling && exp_almost_full) begin
            spill_left = spill_size;
            spill_prod = (p_cnt > spill_thr);
         end else if (exp_spilling && overflow_ready) begin
            spill_left--;
         end

         if (cfg_wr.valid) begin
            case (cfg_wr.addr)
               task_unit_cfg_pkg::CFG_SPILL_THRESHOLD: spill_thr = int'(cfg_wr.data);
               task_unit_cfg_pkg::CFG_SPILL_SIZE: spill_size = int'(cfg_wr.data[7:0]);
               task_unit_cfg_pkg::CFG_PRODUCER_PRIORITY_THRESHOLD: prio_thr = int'(cfg_wr.data);
               default: begin
               end
            endcase
         end
      end
   end

endmodule

//--- sim/tb_task_unit.sv
`timescale 1ns/1ps

module tb_task_unit;

   localparam int LOG_DEPTH  = task_unit_pkg::LOG_TQ_SIZE;
   localparam int WAIT_LIMIT = 3000;

   logic                          clk;
   logic                          rstn;
   logic                          task_enq_valid;
   logic                          task_enq_ready;
   task_unit_pkg::task_t          task_enq_data;
   logic                          coal_child_valid;
   logic                          coal_child_ready;
   task_unit_pkg::task_t          coal_child_data;
   logic                          overflow_ready;
   logic                          overflow_valid;
   task_unit_pkg::task_t          overflow_data;
   logic                          task_deq_ready;
   logic                          task_deq_valid;
   task_unit_pkg::task_t          task_deq_data;
   logic                          splitter_deq_ready;
   logic                          splitter_deq_valid;
   task_unit_pkg::task_t          splitter_deq_task;
   task_unit_cfg_pkg::cfg_write_t cfg_wr;
   logic                          full;
   logic                          almost_full;
   logic                          empty;
   logic                          enq_fire;
   logic                          coal_fire;
   int                            error_count;
   int                            check_count;
   int                            spill_transfers;
   int                            seed;
   int                            enq_pct;
   int                            deq_pct;
   bit                            run_ok;

   task_unit_unordered #(.LOG_DEPTH(LOG_DEPTH)) task_unit_unordered_i (.*);

   task_unit_checker #(.LOG_DEPTH(LOG_DEPTH)) task_unit_checker_i (.*);

   initial clk = 1'b0;
   always #2 clk = ~clk;

   // Sources hold a task until it is taken
   always @(posedge clk) begin
      enq_fire  <= task_enq_valid & task_enq_ready;
      coal_fire <= coal_child_valid & coal_child_ready;
   end

   function automatic bit chance(input int pct);
      return ({$random(seed)} % 100) < pct;
   endfunction

   function automatic task_unit_pkg::task_t make_task(input logic producer);
      task_unit_pkg::task_t t;
      t.ttype    = 4'($random(seed));
      t.locale   = $random(seed);
      t.ts       = $random(seed);
      t.producer = producer;
      t.args     = $random(seed);
      if (producer && chance(50)) begin
         t.ttype = task_unit_pkg::TASK_TYPE_SPLITTER;
      end
      return t;
   endfunction

   task automatic drive_random();
      if (!task_enq_valid || enq_fire) begin
         task_enq_valid = chance(enq_pct);
         task_enq_data  = make_task(chance(40));
      end
      if (!coal_child_valid || coal_fire) begin
         coal_child_valid = chance(enq_pct / 2);
         coal_child_data  = make_task(1'b0);
      end
      task_deq_ready     = chance(deq_pct);
      splitter_deq_ready = chance(deq_pct);
      overflow_ready     = chance(50);
      cfg_wr             = '0;
   endtask

   task automatic run_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         drive_random();
      end
   endtask

   task automatic write_cfg(input logic [7:0] addr, input logic [15:0] data);
      @(negedge clk);
      drive_random();
      cfg_wr.valid = 1'b1;
      cfg_wr.addr  = addr;
      cfg_wr.data  = data;
   endtask

   task automatic wait_for_spill(output bit ok);
      int waited;
      waited = 0;
      @(negedge clk);
      cfg_wr = '0;
      while (!overflow_valid && waited < WAIT_LIMIT) begin
         drive_random();
         @(negedge clk);
         waited++;
      end
      ok = overflow_valid;
      if (!ok) begin
         $display("Timed out waiting for a spill to start");
      end
   endtask

   task automatic drain_queues(output bit ok);
      int waited;
      waited = 0;
      @(negedge clk);
      while (!(empty && !task_deq_valid && !splitter_deq_valid && !overflow_valid) &&
             waited < WAIT_LIMIT) begin
         task_enq_valid     = 1'b0;
         coal_child_valid   = 1'b0;
         task_deq_ready     = 1'b1;
         splitter_deq_ready = 1'b1;
         overflow_ready     = 1'b1;
         cfg_wr             = '0;
         @(negedge clk);
         waited++;
      end
      ok = empty && !task_deq_valid && !splitter_deq_valid && !overflow_valid;
      if (!ok) begin
         $display("Timed out waiting for the queues to drain");
      end
   endtask

   initial begin
      seed               = 18992;
      rstn               = 1'b0;
      task_enq_valid     = 1'b0;
      task_enq_data      = '0;
      coal_child_valid   = 1'b0;
      coal_child_data    = '0;
      overflow_ready     = 1'b0;
      task_deq_ready     = 1'b0;
      splitter_deq_ready = 1'b0;
      cfg_wr             = '0;
      enq_pct            = 50;
      deq_pct            = 50;
      repeat (2) @(negedge clk);
      rstn = 1'b1;

      run_cycles(200);

      // Spill size first so it stays below every threshold
      write_cfg(task_unit_cfg_pkg::CFG_SPILL_SIZE, 16'd6);
      write_cfg(task_unit_cfg_pkg::CFG_SPILL_THRESHOLD, 16'd20);
      write_cfg(task_unit_cfg_pkg::CFG_PRODUCER_PRIORITY_THRESHOLD, 16'd10);
      write_cfg(8'h44, 16'd3);
      enq_pct = 85;
      deq_pct = 25;
      wait_for_spill(run_ok);
      if (run_ok) begin
         for (int i = 0; i < 4; i++) begin
            run_cycles(120);
            write_cfg(task_unit_cfg_pkg::CFG_SPILL_SIZE, 16'(2 + {$random(seed)} % 9));
            write_cfg(task_unit_cfg_pkg::CFG_SPILL_THRESHOLD, 16'(12 + {$random(seed)} % 19));
            write_cfg(task_unit_cfg_pkg::CFG_PRODUCER_PRIORITY_THRESHOLD,
                      16'(1 + {$random(seed)} % 40));
            deq_pct = 20 + {$random(seed)} % 60;
         end
         drain_queues(run_ok);
      end

      @(negedge clk);
      if (spill_transfers == 0) begin
         $display("No overflow transfer was seen during the run");
      end
      $display("checks: %0d  errors: %0d  overflow transfers: %0d",
               check_count, error_count, spill_transfers);
      if (run_ok && error_count == 0 && spill_transfers > 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- task_unit_unordered.f
source/task_unit_pkg.sv
source/task_unit_cfg_pkg.sv
source/task_fifo.sv
source/admit_spill_ctrl.sv
source/deq_arbiter.sv
source/task_unit_regs.sv
source/task_unit_unordered.sv
sim/task_unit_checker.sv
sim/tb_task_unit.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_task_unit
FILELIST  = task_unit_unordered.f
OBJ_DIR   = obj_dir
PASS_MSG  = TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
